/* source/vred_pkg.sv */
package vred_pkg;

    localparam int VEC_BITS = 512;
    localparam int SCALAR_BITS = 32;
    localparam int QUARTER_BITS = VEC_BITS / 4;
    localparam int QUEUE_DEPTH = 2;
    localparam int QPTR_BITS = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int QCNT_BITS = $clog2(QUEUE_DEPTH + 1);

    // halving steps for one quarter of bytes; lmul adds, sew subtracts
    localparam int HALVE_BASE = $clog2(QUARTER_BITS / 8);
    localparam int STEP_BITS = 3;

    typedef logic [VEC_BITS-1:0] vec_t;
    typedef logic [SCALAR_BITS-1:0] scalar_t;

    typedef enum logic [1:0] {
        SEW_8  = 2'b00,
        SEW_16 = 2'b01,
        SEW_32 = 2'b10
    } sew_e;

    typedef enum logic [1:0] {
        LMUL_1 = 2'b00,
        LMUL_2 = 2'b01,
        LMUL_4 = 2'b10
    } lmul_e;

    typedef enum logic {
        RED_SUM = 1'b0,
        RED_MAX = 1'b1
    } red_op_e;

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        HALVE,
        FINISH
    } eng_state_e;

    typedef struct packed {
        red_op_e op;
        sew_e    sew;
        lmul_e   lmul;
        vec_t    vec;
        scalar_t scalar;
    } red_req_t;

    localparam logic [7:0] MAX_ID_8 = 8'h80;
    localparam logic [15:0] MAX_ID_16 = 16'h8000;
    localparam logic [31:0] MAX_ID_32 = 32'h8000_0000;

    // whole vector of identity elements for the given op and width
    function automatic vec_t identity_fill(red_op_e op, sew_e sew);
        vec_t fill;
        fill = '0;
        if (op == RED_MAX)
        begin
            case (sew)
                SEW_8: fill = {(VEC_BITS / 8){MAX_ID_8}};
                SEW_16: fill = {(VEC_BITS / 16){MAX_ID_16}};
                default: fill = {(VEC_BITS / 32){MAX_ID_32}};
            endcase
        end
        return fill;
    endfunction

endpackage

/* source/vred_req_queue.sv */
`timescale 1ns/1ns

module vred_req_queue import vred_pkg::*;
(
    input  logic     clk,
    input  logic     nrst,
    input  logic     req_valid,
    input  red_req_t req,
    input  logic     pop,
    output logic     head_valid,
    output red_req_t head,
    output logic     credit_return
);

    red_req_t mem [QUEUE_DEPTH];
    logic [QPTR_BITS-1:0] wr_ptr;
    logic [QPTR_BITS-1:0] rd_ptr;
    logic [QCNT_BITS-1:0] count;

    function automatic logic [QPTR_BITS-1:0] next_ptr(logic [QPTR_BITS-1:0] ptr);
        logic [QPTR_BITS-1:0] nxt;
        if (ptr == QPTR_BITS'(QUEUE_DEPTH - 1))
            nxt = '0;
        else
            nxt = ptr + 1'b1;
        return nxt;
    endfunction

    assign head_valid = (count != '0);
    assign head = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (req_valid)
            mem[wr_ptr] <= req;
    end

    always_ff @(posedge clk)
    begin
        if (!nrst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            credit_return <= 1'b0;
        end
        else
        begin
            // one credit back per entry handed to the engine
            credit_return <= pop;

            if (req_valid)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);

            case ({req_valid, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* source/vred_lane_op.sv */
`timescale 1ns/1ns

module vred_lane_op import vred_pkg::*;
(
    input  vec_t    acc_in,
    input  red_op_e op,
    input  sew_e    sew,
    output vec_t    acc_out
);

    localparam int HALF_BITS = VEC_BITS / 2;

    // one row per element width: 8, 16, 32
    logic [2:0][HALF_BITS-1:0] half;
    logic [HALF_BITS-1:0] low;
    vec_t fill;

    for (genvar w = 0; w < 3; w++)
    begin : g_width
        localparam int EW = 8 << w;

        for (genvar i = 0; i < HALF_BITS / EW; i++)
        begin : g_pair
            logic signed [EW-1:0] a;
            logic signed [EW-1:0] b;
            logic [EW-1:0] sum;
            logic [EW-1:0] max;

            assign a = acc_in[2*EW*i +: EW];
            assign b = acc_in[2*EW*i+EW +: EW];

            // sum wraps inside the element
            assign sum = a + b;
            assign max = (a >= b) ? a : b;

            assign half[w][EW*i +: EW] = (op == RED_MAX) ? max : sum;
        end
    end

    always_comb
    begin
        case (sew)
            SEW_8: low = half[0];
            SEW_16: low = half[1];
            default: low = half[2];
        endcase
    end

    // upper half refilled with identity, so the next pass needs no group size
    assign fill = identity_fill(op, sew);
    assign acc_out = {fill[VEC_BITS-1:HALF_BITS], low};

endmodule

/* source/vred_engine.sv */
`timescale 1ns/1ns

module vred_engine import vred_pkg::*;
(
    input  logic     clk,
    input  logic     nrst,
    input  logic     head_valid,
    input  red_req_t head,
    output logic     pop,
    output logic     result_valid,
    output scalar_t  result
);

    eng_state_e state;
    red_op_e cur_op;
    sew_e cur_sew;
    lmul_e cur_lmul;
    scalar_t cur_scalar;
    vec_t acc;
    vec_t keep;
    vec_t fill;
    vec_t lane_in;
    vec_t lane_out;
    logic [STEP_BITS-1:0] steps;

    assign pop = (state == IDLE) && head_valid;
    assign fill = identity_fill(cur_op, cur_sew);

    // active quarters, lowest first
    always_comb
    begin
        case (cur_lmul)
            LMUL_1: keep = {{(VEC_BITS - QUARTER_BITS){1'b0}}, {QUARTER_BITS{1'b1}}};
            LMUL_2: keep = {{(VEC_BITS - 2*QUARTER_BITS){1'b0}}, {(2*QUARTER_BITS){1'b1}}};
            default: keep = '1;
        endcase
    end

    // in FINISH the scalar element sits in slot 1, next to the reduced element 0
    always_comb
    begin
        lane_in = acc;
        if (state == FINISH)
        begin
            case (cur_sew)
                SEW_8: lane_in[15:8] = cur_scalar[7:0];
                SEW_16: lane_in[31:16] = cur_scalar[15:0];
                default: lane_in[63:32] = cur_scalar;
            endcase
        end
    end

    vred_lane_op u_lane_op (
        .acc_in  (lane_in),
        .op      (cur_op),
        .sew     (cur_sew),
        .acc_out (lane_out)
    );

    always_ff @(posedge clk)
    begin
        if (!nrst)
        begin
            state <= IDLE;
            steps <= '0;
            result_valid <= 1'b0;
        end
        else
        begin
            result_valid <= 1'b0;
            case (state)
                IDLE:
                begin
                    if (head_valid)
                        state <= LOAD;
                end
                LOAD:
                begin
                    // log2 of the active element count
                    steps <= STEP_BITS'(HALVE_BASE + cur_lmul - cur_sew);
                    state <= HALVE;
                end
                HALVE:
                begin
                    steps <= steps - 1'b1;
                    if (steps == STEP_BITS'(1))
                        state <= FINISH;
                end
                FINISH:
                begin
                    result_valid <= 1'b1;
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        case (state)
            IDLE:
            begin
                if (pop)
                begin
                    acc <= head.vec;
                    cur_op <= head.op;
                    cur_sew <= head.sew;
                    cur_lmul <= head.lmul;
                    cur_scalar <= head.scalar;
                end
            end
            LOAD:
            begin
                // elements outside the group become the identity
                acc <= (acc & keep) | (fill & ~keep);
            end
            HALVE:
            begin
                acc <= lane_out;
            end
            FINISH:
            begin
                case (cur_sew)
                    SEW_8: result <= {24'b0, lane_out[7:0]};
                    SEW_16: result <= {16'b0, lane_out[15:0]};
                    default: result <= lane_out[31:0];
                endcase
            end
            default:
            begin
                acc <= acc;
            end
        endcase
    end

endmodule

/* source/vred_top.sv */
`timescale 1ns/1ns

module vred_top import vred_pkg::*;
(
    input  logic     clk,
    input  logic     nrst,
    input  logic     req_valid,
    input  red_req_t req,
    output logic     credit_return,
    output logic     result_valid,
    output scalar_t  result
);

    logic head_valid;
    logic pop;
    red_req_t head;

    vred_req_queue u_queue (
        .clk           (clk),
        .nrst          (nrst),
        .req_valid     (req_valid),
        .req           (req),
        .pop           (pop),
        .head_valid    (head_valid),
        .head          (head),
        .credit_return (credit_return)
    );

    vred_engine u_engine (
        .clk          (clk),
        .nrst         (nrst),
        .head_valid   (head_valid),
        .head         (head),
        .pop          (pop),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

/* testbench/vred_properties.sv */
`timescale 1ns/1ns

module vred_properties import vred_pkg::*;
(
    input logic     clk,
    input logic     nrst,
    input logic     req_valid,
    input red_req_t req,
    input logic     credit_return,
    input logic     result_valid
);

    int outstanding;
    int unsigned fail_count = 0;

    // requests sent but not yet credited back
    always_ff @(posedge clk)
    begin
        if (!nrst)
            outstanding <= 0;
        else
            outstanding <= outstanding + int'(req_valid) - int'(credit_return);
    end

    credit_bound: assert property (@(posedge clk) disable iff (!nrst)
        outstanding <= QUEUE_DEPTH)
    else
    begin
        fail_count++;
        $error("more than %0d requests outstanding without credit", QUEUE_DEPTH);
    end

    reset_quiet: assert property (@(posedge clk)
        !nrst |=> !result_valid && !credit_return)
    else
    begin
        fail_count++;
        $error("result_valid or credit_return high during or right after reset");
    end

    legal_encoding: assert property (@(posedge clk) disable iff (!nrst)
        req_valid |-> req.sew inside {SEW_8, SEW_16, SEW_32} &&
            req.lmul inside {LMUL_1, LMUL_2, LMUL_4})
    else
    begin
        fail_count++;
        $error("request with a reserved element width or group size");
    end

    single_result: assert property (@(posedge clk) disable iff (!nrst)
        result_valid |=> !result_valid)
    else
    begin
        fail_count++;
        $error("result_valid high on two consecutive cycles");
    end

endmodule

bind vred_top vred_properties u_props (
    .clk           (clk),
    .nrst          (nrst),
    .req_valid     (req_valid),
    .req           (req),
    .credit_return (credit_return),
    .result_valid  (result_valid)
);

/* include/vred_ref_model.svh */
`ifndef VRED_REF_MODEL_SVH
`define VRED_REF_MODEL_SVH

// element idx of width ew with sign extension when sgn is set
function automatic longint element_value(vred_pkg::vec_t v, int idx, int ew, bit sgn);
    longint val;
    val = longint'(v >> (idx * ew)) & ((longint'(1) << ew) - 1);
    if (sgn && val >= (longint'(1) << (ew - 1)))
        val = val - (longint'(1) << ew);
    return val;
endfunction

// expected zero-extended result of one request
function automatic vred_pkg::scalar_t expected_result(vred_pkg::red_req_t r);
    int ew;
    int n;
    bit is_max;
    longint acc;
    longint elem;
    ew = 8 << int'(r.sew);
    n = (vred_pkg::QUARTER_BITS << int'(r.lmul)) / ew;
    is_max = (r.op == vred_pkg::RED_MAX);
    acc = element_value(vred_pkg::vec_t'(r.scalar), 0, ew, is_max);
    for (int i = 0; i < n; i++)
    begin
        elem = element_value(r.vec, i, ew, is_max);
        if (!is_max)
            acc = acc + elem;
        else if (elem > acc)
            acc = elem;
    end
    return vred_pkg::scalar_t'(acc & ((longint'(1) << ew) - 1));
endfunction

// engine cycles from pop to result_valid
function automatic int engine_latency(vred_pkg::red_req_t r);
    int ew;
    int n;
    ew = 8 << int'(r.sew);
    n = (vred_pkg::QUARTER_BITS << int'(r.lmul)) / ew;
    return $clog2(n) + 3;
endfunction

`endif

/* testbench/vred_tb.sv */
`timescale 1ns/1ns

module vred_tb import vred_pkg::*;
();

    localparam int HALF_PERIOD = 50;
    localparam int DRIVE_DLY = 10;
    localparam int CREDIT_LIMIT = 50;

    logic clk;
    logic nrst;
    logic req_valid;
    red_req_t req;
    logic credit_return;
    logic result_valid;
    scalar_t result;

    scalar_t exp_q[$];
    scalar_t exp_head;
    logic exp_avail;
    int credits;
    int credit_pulses;
    int pulses_before;
    int checked;
    int errors;
    int errs_at_start;
    int budget;
    int sent;
    int tests_run;
    int tests_failed;
    bit timed_out;

    `include "vred_ref_model.svh"

    vred_top dut (
        .clk           (clk),
        .nrst          (nrst),
        .req_valid     (req_valid),
        .req           (req),
        .credit_return (credit_return),
        .result_valid  (result_valid),
        .result        (result)
    );

    initial
    begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // sender side credit count and retiring of checked results
    always @(posedge clk)
    begin
        if (!nrst)
            credits <= QUEUE_DEPTH;
        else
            credits <= credits - int'(req_valid) + int'(credit_return);
        if (nrst && credit_return)
            credit_pulses <= credit_pulses + 1;
        if (nrst && result_valid && exp_avail)
        begin
            checked <= checked + 1;
            exp_q.delete(0);
            refresh_head();
        end
    end

    check_result: assert property (@(posedge clk) disable iff (!nrst)
        result_valid && exp_avail |-> result == exp_head)
    else
    begin
        errors++;
        $error("MISMATCH at %0t: expected %h, got %h", $time, $sampled(exp_head),
            $sampled(result));
    end

    no_stray_result: assert property (@(posedge clk) disable iff (!nrst)
        result_valid |-> exp_avail)
    else
    begin
        errors++;
        $error("result_valid came at %0t with no request outstanding", $time);
    end

    function automatic void refresh_head();
        exp_avail = (exp_q.size() != 0);
        exp_head = exp_avail ? exp_q[0] : '0;
    endfunction

    function automatic int total_errors();
        return errors + int'(dut.u_props.fail_count);
    endfunction

    function automatic red_req_t make_req(red_op_e op, sew_e sew, lmul_e lmul);
        red_req_t r;
        r.op = op;
        r.sew = sew;
        r.lmul = lmul;
        for (int i = 0; i < VEC_BITS / 32; i++)
            r.vec[32*i +: 32] = $urandom;
        r.scalar = $urandom;
        return r;
    endfunction

    // sign bit set in every active element and in the scalar
    function automatic red_req_t force_negative(red_req_t r);
        logic [31:0] mask;
        red_req_t n;
        n = r;
        case (r.sew)
            SEW_8: mask = 32'h8080_8080;
            SEW_16: mask = 32'h8000_8000;
            default: mask = 32'h8000_0000;
        endcase
        for (int i = 0; i < (QUARTER_BITS << int'(r.lmul)) / 32; i++)
            n.vec[32*i +: 32] = n.vec[32*i +: 32] | mask;
        n.scalar = n.scalar | mask;
        return n;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic reset_dut();
        nrst = 1'b0;
        req_valid = 1'b0;
        exp_q.delete();
        refresh_head();
        budget = 0;
        repeat (3) next_cycle();
        nrst = 1'b1;
    endtask

    task automatic send_req(input red_req_t r);
        int waited;
        waited = 0;
        while (credits == 0 && waited < CREDIT_LIMIT)
        begin
            next_cycle();
            waited++;
        end
        if (credits == 0)
        begin
            timed_out = 1'b1;
            $display("timeout: no credit came back for request %0d", sent + 1);
        end
        else
        begin
            req = r;
            req_valid = 1'b1;
            exp_q.push_back(expected_result(r));
            refresh_head();
            budget += engine_latency(r) + 2;
            sent++;
            next_cycle();
            req_valid = 1'b0;
        end
    endtask

    // wait for every expected result and every credit
    task automatic drain(input string name);
        int waited;
        waited = 0;
        while ((exp_q.size() != 0 || credits != QUEUE_DEPTH) && waited < budget + 20)
        begin
            next_cycle();
            waited++;
        end
        if (exp_q.size() != 0)
        begin
            timed_out = 1'b1;
            $display("timeout in %s: result of request %0d never came", name,
                sent - exp_q.size() + 1);
        end
        else if (credits != QUEUE_DEPTH)
        begin
            timed_out = 1'b1;
            $display("timeout in %s: credits never came back", name);
        end
        budget = 0;
    endtask

    task automatic end_test(input string name);
        drain(name);
        tests_run++;
        if (timed_out || total_errors() != errs_at_start)
        begin
            tests_failed++;
            $display("test %0d, %s: failed", tests_run, name);
        end
        else
            $display("test %0d, %s: ok", tests_run, name);
        timed_out = 1'b0;
    endtask

    task automatic check_credit_pulses(input int expected);
        assert (credit_pulses - pulses_before == expected)
        else
        begin
            errors++;
            $error("MISMATCH at %0t: %0d credit returns for %0d requests", $time,
                credit_pulses - pulses_before, expected);
        end
    endtask

    initial
    begin
        red_req_t r;
        void'($urandom(32'h7010c46e));
        req = '0;
        req_valid = 1'b0;
        timed_out = 1'b0;
        reset_dut();

        errs_at_start = total_errors();
        for (int s = 0; s < 3; s++)
            repeat (3) send_req(make_req(RED_SUM, sew_e'(s), LMUL_1));
        end_test("sum at group size 1");

        errs_at_start = total_errors();
        for (int s = 0; s < 3; s++)
        begin
            send_req(make_req(RED_MAX, sew_e'(s), LMUL_1));
            send_req(force_negative(make_req(RED_MAX, sew_e'(s), LMUL_1)));
        end
        end_test("signed max at group size 1");

        errs_at_start = total_errors();
        for (int l = 1; l < 3; l++)
            for (int o = 0; o < 2; o++)
                for (int s = 0; s < 3; s++)
                    send_req(make_req(red_op_e'(o), sew_e'(s), lmul_e'(l)));
        end_test("group sizes 2 and 4");

        errs_at_start = total_errors();
        for (int s = 0; s < 3; s++)
        begin
            r = force_negative(make_req(RED_MAX, sew_e'(s), lmul_e'(s)));
            // low scalar element positive so it beats every element
            r.scalar[(8 << s) - 1] = 1'b0;
            send_req(r);
        end
        end_test("dominant scalar");

        errs_at_start = total_errors();
        pulses_before = credit_pulses;
        repeat (8)
            send_req(make_req(red_op_e'($urandom_range(1, 0)), sew_e'($urandom_range(2, 0)),
                lmul_e'($urandom_range(2, 0))));
        drain("back to back");
        check_credit_pulses(8);
        end_test("back to back");

        errs_at_start = total_errors();
        send_req(make_req(RED_SUM, SEW_8, LMUL_4));
        repeat (4) next_cycle();
        reset_dut();
        pulses_before = credit_pulses;
        repeat (QUEUE_DEPTH) send_req(make_req(RED_MAX, SEW_16, LMUL_2));
        drain("reset during a request");
        check_credit_pulses(QUEUE_DEPTH);
        end_test("reset during a request");

        next_cycle();
        $display("%0d tests run, %0d failed, %0d results checked, %0d errors", tests_run,
            tests_failed, checked, total_errors());
        if (tests_failed == 0 && total_errors() == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

/* list.f */
+incdir+include
source/vred_pkg.sv
source/vred_req_queue.sv
source/vred_lane_op.sv
source/vred_engine.sv
source/vred_top.sv
testbench/vred_properties.sv
testbench/vred_tb.sv
